// File: src/trs_fpga_pkg.sv
package trs_fpga_pkg;

  // host command opcodes
  typedef enum logic [7:0] {
    get_cookie       = 8'd0,
    get_version      = 8'd15,
    get_mode         = 8'd16,
    set_led          = 8'd26,
    get_config       = 8'd27,
    set_spi_ctrl_reg = 8'd29,
    set_spi_data     = 8'd30,
    get_spi_data     = 8'd31
  } cmd_op_e;

  localparam logic [7:0] cookie_c        = 8'hAF;
  localparam logic [2:0] version_major_c = 3'd0;
  localparam logic [4:0] version_minor_c = 5'd3;

  // pocket-trs model 3
  localparam logic [3:0] board_mode_c   = 4'b0011;
  localparam logic       dip4_mode_en_c = 1'b1;

  localparam int sync_stages_c    = 3;
  localparam int flash_bit_clks_c = 16;
  // run counter bit that serves as flash sck
  localparam int flash_sck_bit_c  = $clog2(flash_bit_clks_c) - 1;

  typedef struct packed {
    logic sck;
    logic mosi;
    logic cs_n;
  } spi_pins_t;

  typedef struct packed {
    logic cs_n;
    logic sck;
    logic si;
  } flash_pins_t;

  typedef struct packed {
    cmd_op_e    opcode;
    logic [7:0] param;
  } cmd_action_t;

  // flash control byte, bit 7 cs active high, bit 6 write protect
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic       cs;
      logic       wpn;
      logic [5:0] spare;
    } f;
  } spi_ctrl_u;

  function automatic logic op_known_f(logic [7:0] code);
    case (code)
      get_cookie, get_version, get_mode, set_led, get_config,
      set_spi_ctrl_reg, set_spi_data, get_spi_data: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // commands that carry a parameter byte
  function automatic logic op_has_param_f(cmd_op_e op);
    case (op)
      set_led, set_spi_ctrl_reg, set_spi_data: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

endpackage

// File: src/esp_spi_slave.sv
`timescale 1ns/1ps

module esp_spi_slave (
  input  logic                    clk,
  input  logic                    cass_out_sel_n,
  input  trs_fpga_pkg::spi_pins_t spi_in,
  input  logic [7:0]              reply,
  output logic [7:0]              rx_byte,
  output logic                    byte_valid,
  output logic                    miso
);
  import trs_fpga_pkg::*;

  logic [sync_stages_c-1:0] sck_sync;
  logic [sync_stages_c-1:0] cs_sync;
  logic [sync_stages_c-2:0] mosi_sync;
  logic                     sck_rise;
  logic                     sck_fall;
  logic                     cs_active;
  logic [2:0]               bit_cnt;
  logic [7:0]               tx_shift;

  // host pins cross into the clk domain
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      sck_sync  <= '0;
      cs_sync   <= '1;
      mosi_sync <= '0;
    end else begin
      sck_sync  <= {sck_sync[sync_stages_c-2:0], spi_in.sck};
      cs_sync   <= {cs_sync[sync_stages_c-2:0], spi_in.cs_n};
      mosi_sync <= {mosi_sync[sync_stages_c-3:0], spi_in.mosi};
    end
  end

  assign sck_rise  = sck_sync[sync_stages_c-1 -: 2] == 2'b01;
  assign sck_fall  = sck_sync[sync_stages_c-1 -: 2] == 2'b10;
  assign cs_active = ~cs_sync[sync_stages_c-1];

  // receive side, msb first
  always_ff @(posedge clk) begin
    if (cs_active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], mosi_sync[sync_stages_c-2]};
    end
  end

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      bit_cnt    <= 3'd0;
      byte_valid <= 1'b0;
      tx_shift   <= 8'h00;
    end else begin
      byte_valid <= 1'b0;
      if (!cs_active) begin
        bit_cnt <= 3'd0;
      end else begin
        if (sck_rise) begin
          bit_cnt <= bit_cnt + 3'd1;
          if (bit_cnt == 3'd7) begin
            byte_valid <= 1'b1;
          end
        end
        // first falling edge of a byte grabs the reply
        if (sck_fall) begin
          if (bit_cnt == 3'd1) begin
            tx_shift <= reply;
          end else begin
            tx_shift <= {tx_shift[6:0], 1'b0};
          end
        end
      end
    end
  end

  // low when deselected, no tri-state
  assign miso = cs_active & tx_shift[7];

endmodule

// File: src/cmd_parser.sv
`timescale 1ns/1ps

module cmd_parser (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic [7:0]                rx_byte,
  input  logic                      byte_valid,
  output logic                      action,
  output trs_fpga_pkg::cmd_action_t act,
  output logic                      err_set
);
  import trs_fpga_pkg::*;

  typedef enum logic {
    st_idle,
    st_read_param
  } state_e;

  state_e  state;
  cmd_op_e rx_op;
  logic    rx_known;

  assign rx_op    = cmd_op_e'(rx_byte);
  assign rx_known = op_known_f(rx_byte);

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      state   <= st_idle;
      action  <= 1'b0;
      err_set <= 1'b0;
    end else begin
      action  <= 1'b0;
      err_set <= 1'b0;
      if (byte_valid) begin
        case (state)
          st_idle: begin
            if (!rx_known) begin
              // unknown opcode, stay idle
              err_set <= 1'b1;
            end else if (op_has_param_f(rx_op)) begin
              state <= st_read_param;
            end else begin
              action <= 1'b1;
            end
          end
          st_read_param: begin
            action <= 1'b1;
            state  <= st_idle;
          end
          default: begin
            state <= st_idle;
          end
        endcase
      end
    end
  end

  // opcode and parameter travel with the strobe
  always_ff @(posedge clk) begin
    if (byte_valid) begin
      if (state == st_idle) begin
        if (rx_known) begin
          act.opcode <= rx_op;
          act.param  <= 8'h00;
        end
      end else begin
        act.param <= rx_byte;
      end
    end
  end

endmodule

// File: src/cmd_regs.sv
`timescale 1ns/1ps

module cmd_regs (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic                      action,
  input  trs_fpga_pkg::cmd_action_t act,
  input  logic                      err_set,
  input  logic [3:0]                conf,
  input  logic [7:0]                spi_data,
  output logic [7:0]                reply,
  output logic                      led_red,
  output logic                      led_green,
  output logic                      led_blue,
  output logic                      err_led
);
  import trs_fpga_pkg::*;

  logic [3:0] mode;

  // dip switch 4 off selects the model 3 variant
  assign mode = board_mode_c | {dip4_mode_en_c & ~conf[3], 3'b000};

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      led_red   <= 1'b0;
      led_green <= 1'b0;
      led_blue  <= 1'b0;
      reply     <= 8'h00;
    end else if (action) begin
      case (act.opcode)
        get_cookie:   reply <= cookie_c;
        get_version:  reply <= {version_major_c, version_minor_c};
        get_mode:     reply <= {4'b0000, mode};
        get_config:   reply <= {4'b0000, ~conf};
        get_spi_data: reply <= spi_data;
        set_led: begin
          led_red   <= act.param[0];
          led_green <= act.param[1];
          led_blue  <= act.param[2];
        end
        default: begin
        end
      endcase
    end
  end

  // sticky until reset
  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      err_led <= 1'b0;
    end else if (err_set) begin
      err_led <= 1'b1;
    end
  end

endmodule

// File: src/flash_spi_master.sv
`timescale 1ns/1ps

module flash_spi_master (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  logic                      action,
  input  trs_fpga_pkg::cmd_action_t act,
  input  logic                      flash_so,
  output trs_fpga_pkg::flash_pins_t flash,
  output logic [7:0]                shift_data
);
  import trs_fpga_pkg::*;

  spi_ctrl_u  ctrl;
  logic [7:0] run_cnt;
  logic [7:0] shift_reg;
  logic       sdo;
  logic       start;
  logic       phase_edge;

  // a new byte while running is dropped
  assign start      = action && act.opcode == set_spi_data && !run_cnt[7];
  assign phase_edge = run_cnt[flash_sck_bit_c-1:0] == '0;

  always_ff @(posedge clk or negedge cass_out_sel_n) begin
    if (!cass_out_sel_n) begin
      ctrl.raw  <= 8'h00;
      run_cnt   <= 8'h00;
      shift_reg <= 8'h00;
      sdo       <= 1'b0;
    end else begin
      if (action && act.opcode == set_spi_ctrl_reg) begin
        ctrl.raw <= act.param;
      end
      if (run_cnt[7]) begin
        // bit 7 wraps to zero after 128 cycles
        run_cnt <= run_cnt + 8'd1;
        if (phase_edge) begin
          if (!run_cnt[flash_sck_bit_c]) begin
            sdo <= shift_reg[7];
          end else begin
            shift_reg <= {shift_reg[6:0], flash_so};
          end
        end
      end else if (start) begin
        shift_reg <= act.param;
        run_cnt   <= 8'h80;
      end
    end
  end

  assign flash.cs_n = ~ctrl.f.cs;
  assign flash.sck  = run_cnt[flash_sck_bit_c];
  assign flash.si   = sdo;
  assign shift_data = shift_reg;

endmodule

// File: src/trs_fpga_top.sv
`timescale 1ns/1ps

module trs_fpga_top (
  input  logic                      clk,
  input  logic                      cass_out_sel_n,
  input  trs_fpga_pkg::spi_pins_t   spi_in,
  output logic                      miso,
  input  logic [3:0]                conf,
  output logic                      led_red,
  output logic                      led_green,
  output logic                      led_blue,
  output logic                      err_led,
  output trs_fpga_pkg::flash_pins_t flash,
  input  logic                      flash_so
);
  import trs_fpga_pkg::*;

  logic [7:0]  rx_byte;
  logic        byte_valid;
  logic [7:0]  reply;
  logic        action;
  cmd_action_t act;
  logic        err_set;
  logic [7:0]  shift_data;

  esp_spi_slave esp_spi_slave_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .spi_in         (spi_in),
    .reply          (reply),
    .rx_byte        (rx_byte),
    .byte_valid     (byte_valid),
    .miso           (miso)
  );

  cmd_parser cmd_parser_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .rx_byte        (rx_byte),
    .byte_valid     (byte_valid),
    .action         (action),
    .act            (act),
    .err_set        (err_set)
  );

  cmd_regs cmd_regs_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .action         (action),
    .act            (act),
    .err_set        (err_set),
    .conf           (conf),
    .spi_data       (shift_data),
    .reply          (reply),
    .led_red        (led_red),
    .led_green      (led_green),
    .led_blue       (led_blue),
    .err_led        (err_led)
  );

  flash_spi_master flash_spi_master_i (
    .clk            (clk),
    .cass_out_sel_n (cass_out_sel_n),
    .action         (action),
    .act            (act),
    .flash_so       (flash_so),
    .flash          (flash),
    .shift_data     (shift_data)
  );

endmodule

// File: tests/trs_fpga_asserts.sv
`timescale 1ns/1ps

module trs_fpga_asserts (
  input logic                      clk,
  input logic                      cass_out_sel_n,
  input trs_fpga_pkg::spi_pins_t   spi_in,
  input logic                      miso,
  input trs_fpga_pkg::flash_pins_t flash,
  input logic                      err_led
);

  int fail_count = 0;

  // slave sees chip select three clocks late
  property miso_quiet_p;
    @(posedge clk) disable iff (!cass_out_sel_n)
      spi_in.cs_n && $past(spi_in.cs_n, 1) && $past(spi_in.cs_n, 2) && $past(spi_in.cs_n, 3)
        |-> !miso;
  endproperty

  // old level held for 8 clk before any change
  property sck_hold_p;
    @(posedge clk) disable iff (!cass_out_sel_n)
      $changed(flash.sck) |->
        $past(flash.sck, 1) == $past(flash.sck, 2) &&
        $past(flash.sck, 2) == $past(flash.sck, 3) &&
        $past(flash.sck, 3) == $past(flash.sck, 4) &&
        $past(flash.sck, 4) == $past(flash.sck, 5) &&
        $past(flash.sck, 5) == $past(flash.sck, 6) &&
        $past(flash.sck, 6) == $past(flash.sck, 7) &&
        $past(flash.sck, 7) == $past(flash.sck, 8);
  endproperty

  property err_sticky_p;
    @(posedge clk) disable iff (!cass_out_sel_n)
      !$fell(err_led);
  endproperty

  miso_quiet_a: assert property (miso_quiet_p) else begin
    fail_count++;
    $error("miso high while chip select inactive");
  end

  sck_hold_a: assert property (sck_hold_p) else begin
    fail_count++;
    $error("flash sck changed within 8 clk");
  end

  err_sticky_a: assert property (err_sticky_p) else begin
    fail_count++;
    $error("err_led fell outside reset");
  end

endmodule

bind trs_fpga_top trs_fpga_asserts trs_fpga_asserts_i (.*);

// File: tests/tb_trs_fpga.sv
`timescale 1ns/1ps

module tb_trs_fpga;
  import trs_fpga_pkg::*;

  localparam int flash_timeout_c = 1000;

  logic        clk;
  logic        cass_out_sel_n;
  spi_pins_t   spi_in;
  logic        miso;
  logic [3:0]  conf;
  logic        led_red;
  logic        led_green;
  logic        led_blue;
  logic        err_led;
  flash_pins_t flash;
  logic        flash_so;

  cmd_op_e     op;
  logic [7:0]  got;
  logic [7:0]  exp_byte;
  logic [7:0]  param;
  logic [7:0]  so_byte;
  logic [7:0]  seen;
  logic        si_exp;
  int          sel;

  trs_fpga_top trs_fpga_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_byte(input string what, input logic [7:0] got_v, input logic [7:0] exp_v);
    if (got_v !== exp_v) begin
      $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got_v, exp_v);
      stop_run();
    end
  endtask

  task automatic check_bit(input string what, input logic got_v, input logic exp_v);
    if (got_v !== exp_v) begin
      $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got_v, exp_v);
      stop_run();
    end
  endtask

  task automatic check_leds(input logic [2:0] got_v, input logic [2:0] exp_v);
    if (got_v !== exp_v) begin
      $display("CHECK FAILED at %0t: leds (b,g,r) got %b expected %b", $time, got_v, exp_v);
      stop_run();
    end
  endtask

  task automatic check_flash(input flash_pins_t got_v, input flash_pins_t exp_v);
    if (got_v !== exp_v) begin
      $display("CHECK FAILED at %0t: flash (cs_n,sck,si) got %b expected %b",
               $time, got_v, exp_v);
      stop_run();
    end
  endtask

  // wait n rising edges and return 2 ns after the last one
  task automatic clocks(input int n);
    repeat (n) @(posedge clk);
    #2;
  endtask

  task automatic apply_reset();
    cass_out_sel_n = 1'b0;
    spi_in.sck = 1'b0;
    spi_in.mosi = 1'b0;
    spi_in.cs_n = 1'b1;
    flash_so = 1'b0;
    clocks(5);
    cass_out_sel_n = 1'b1;
    clocks(2);
  endtask

  // host frame with sck idling low and each phase lasting 8 clk
  task automatic spi_frame(input logic [23:0] bytes, input int nbytes, output logic [7:0] rx);
    logic [23:0] tx;
    tx = bytes;
    rx = 8'h00;
    spi_in.cs_n = 1'b0;
    clocks(4);
    repeat (nbytes * 8) begin
      spi_in.mosi = tx[23];
      tx = {tx[22:0], 1'b0};
      clocks(4);
      spi_in.sck = 1'b1;
      clocks(8);
      spi_in.sck = 1'b0;
      clocks(4);
      // middle of the low phase
      rx = {rx[6:0], miso};
    end
    clocks(4);
    spi_in.cs_n = 1'b1;
    clocks(4);
  endtask

  // flash device shifting so out msb first after each rising sck
  task automatic run_flash_model(input logic [7:0] so_v, output logic [7:0] si_v);
    logic [7:0] so_shift;
    logic       prev_sck;
    int         edges;
    int         waited;
    so_shift = so_v;
    si_v = 8'h00;
    edges = 0;
    waited = 0;
    flash_so = so_shift[7];
    prev_sck = flash.sck;
    while (edges < 8) begin
      @(posedge clk);
      #1;
      waited++;
      if (waited > flash_timeout_c) begin
        $display("flash SCK rising edge %0d did not come by %0t", edges + 1, $time);
        stop_run();
      end
      if (flash.sck && !prev_sck) begin
        si_v = {si_v[6:0], flash.si};
        edges++;
        waited = 0;
        // master takes so on the clk after sck rises
        @(posedge clk);
        #2;
        so_shift = {so_shift[6:0], 1'b0};
        flash_so = so_shift[7];
      end
      prev_sck = flash.sck;
    end
  endtask

  function automatic logic known_opcode(input logic [7:0] code);
    return code inside {8'd0, 8'd15, 8'd16, 8'd26, 8'd27, 8'd29, 8'd30, 8'd31};
  endfunction

  task automatic check_idle();
    check_leds({led_blue, led_green, led_red}, 3'b000);
    check_bit("err_led", err_led, 1'b0);
    check_bit("miso", miso, 1'b0);
    check_flash(flash, flash_pins_t'(3'b100));
  endtask

  // failures counted by the bound checker
  always @(posedge clk) begin
    if (trs_fpga_top_i.trs_fpga_asserts_i.fail_count != 0) begin
      $display("a bound assertion failed before %0t", $time);
      stop_run();
    end
  end

  initial begin
    cass_out_sel_n = 1'b0;
    spi_in.sck = 1'b0;
    spi_in.mosi = 1'b0;
    spi_in.cs_n = 1'b1;
    conf = 4'h0;
    flash_so = 1'b0;
    si_exp = 1'b0;
    void'($urandom(32'h8d507313));
    apply_reset();

    // cookie straight out of reset
    check_idle();
    spi_frame({get_cookie, 16'h0000}, 2, got);
    check_byte("get_cookie reply", got, 8'haf);

    repeat (24) begin
      conf = 4'($urandom);
      sel = $urandom_range(2);
      case (sel)
        0: begin
          op = get_cookie;
          exp_byte = 8'haf;
        end
        1: begin
          op = get_version;
          exp_byte = 8'h03;
        end
        default: begin
          op = get_mode;
          // dip 4 low turns mode 3 into mode 11
          exp_byte = conf[3] ? 8'h03 : 8'h0b;
        end
      endcase
      spi_frame({op, 16'h0000}, 2, got);
      check_byte("read reply", got, exp_byte);
    end

    repeat (8) begin
      conf = 4'($urandom);
      spi_frame({get_config, 16'h0000}, 2, got);
      check_byte("get_config reply", got, {4'h0, ~conf});
    end

    repeat (8) begin
      param = 8'($urandom);
      spi_frame({set_led, param, 8'h00}, 3, got);
      check_leds({led_blue, led_green, led_red}, param[2:0]);
    end

    repeat (4) begin
      param = 8'($urandom);
      spi_frame({set_spi_ctrl_reg, param, 8'h00}, 2, got);
      check_flash(flash, flash_pins_t'({~param[7], 1'b0, si_exp}));
      param = 8'($urandom);
      so_byte = 8'($urandom);
      fork
        spi_frame({set_spi_data, param, 8'h00}, 2, got);
        run_flash_model(so_byte, seen);
      join
      check_byte("byte seen on flash si", seen, param);
      si_exp = param[0];
      spi_frame({get_spi_data, 16'h0000}, 2, got);
      check_byte("get_spi_data reply", got, so_byte);
    end

    // an unknown opcode sets the sticky error
    do begin
      param = 8'($urandom);
    end while (known_opcode(param));
    spi_frame({param, 16'h0000}, 1, got);
    check_bit("err_led", err_led, 1'b1);
    spi_frame({get_cookie, 16'h0000}, 2, got);
    check_byte("get_cookie reply", got, 8'haf);
    check_bit("err_led", err_led, 1'b1);
    apply_reset();
    check_idle();
    spi_frame({get_cookie, 16'h0000}, 2, got);
    check_byte("get_cookie reply", got, 8'haf);

    clocks(1);
    if (trs_fpga_top_i.trs_fpga_asserts_i.fail_count != 0) begin
      $display("a bound assertion failed before %0t", $time);
      stop_run();
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: trs_fpga.f
src/trs_fpga_pkg.sv
src/esp_spi_slave.sv
src/cmd_parser.sv
src/cmd_regs.sv
src/flash_spi_master.sv
src/trs_fpga_top.sv
tests/trs_fpga_asserts.sv
tests/tb_trs_fpga.sv

// File: Makefile
SIM := obj_dir/Vtb_trs_fpga
SRCS := $(shell cat trs_fpga.f)

.PHONY: all run clean

all: run

$(SIM): trs_fpga.f $(SRCS)
	verilator --binary --timing --assert -f trs_fpga.f --top-module tb_trs_fpga -o Vtb_trs_fpga

run: $(SIM)
	./$(SIM) +verilator+error+limit+10

clean:
	rm -rf obj_dir
